// File: source/uart_pkg.sv
package uart_pkg;

	// defaults handed to uart_top and passed down
	localparam int DEFAULT_DATA_WIDTH     = 8;     // data bits per frame
	localparam bit DEFAULT_PARITY_ENABLED = 1'b1;  // one parity bit after the data
	localparam bit DEFAULT_PARITY_ODD     = 1'b0;  // 0 even, 1 odd
	localparam int DEFAULT_CLOCKS_PER_BIT = 8;     // at least 4 and even

	// receiver line synchronizer depth
	localparam int SYNC_STAGES = 3;

	// bit position inside a frame of up to 16 data bits plus framing
	typedef logic [4:0] bit_count_t;

	// clock count inside one bit period of up to 255 clocks
	typedef logic [7:0] baud_count_t;

	typedef enum logic [1:0] {
		TX_IDLE,       // line high while waiting for a request
		TX_WAIT_TICK,  // frame loaded and waiting for the bit tick
		TX_SEND        // shifting the frame out
	} tx_state_t;

	typedef enum logic [2:0] {
		RX_IDLE,    // waiting for a falling edge
		RX_START,   // counting to the middle of the start bit
		RX_DATA,    // sampling data bits
		RX_PARITY,  // sampling the parity bit
		RX_STOP     // sampling the stop bit
	} rx_state_t;

endpackage

// File: source/uart_tx.sv
`timescale 1ns/10ps

module uart_tx import uart_pkg::*; #(
	parameter int DATA_WIDTH     = DEFAULT_DATA_WIDTH,
	parameter bit PARITY_ENABLED = DEFAULT_PARITY_ENABLED,
	parameter bit PARITY_ODD     = DEFAULT_PARITY_ODD,
	parameter int CLOCKS_PER_BIT = DEFAULT_CLOCKS_PER_BIT
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  i_enable,     // request taken only while idle
	input  logic [DATA_WIDTH-1:0] i_data,       // word captured with the request
	output logic                  o_busy,       // high from acceptance to end of stop bit
	output logic                  o_serial_out  // serial line that idles high
);

	// start + data + optional parity + stop
	localparam int FRAME_BITS = DATA_WIDTH + int'(PARITY_ENABLED) + 2;
	localparam baud_count_t LAST_CLOCK = baud_count_t'(CLOCKS_PER_BIT - 1);
	localparam bit_count_t LAST_BIT = bit_count_t'(FRAME_BITS - 1);

	tx_state_t             state;
	baud_count_t           baud_cnt;    // free running bit-rate divider
	logic                  bit_tick;    // one cycle per bit period
	bit_count_t            bit_cnt;     // index of the bit on the line
	logic                  parity_bit;
	logic [FRAME_BITS-1:0] load_frame;  // frame as built from i_data
	logic [FRAME_BITS-1:0] shift_reg;   // bit 0 goes out next

	// divider runs from reset regardless of traffic
	always_ff @(posedge clk) begin
		if (reset) begin
			baud_cnt <= '0;
		end else if (bit_tick) begin
			baud_cnt <= '0;
		end else begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

	assign bit_tick = (baud_cnt == LAST_CLOCK);

	assign parity_bit = (^i_data) ^ PARITY_ODD;  // even parity inverted for odd

	// frame layout with the lsb leaving first
	generate
		if (PARITY_ENABLED) begin : g_parity
			assign load_frame = {1'b1, parity_bit, i_data, 1'b0};
		end else begin : g_no_parity
			assign load_frame = {1'b1, i_data, 1'b0};
		end
	endgenerate

	// frame shift register
	always_ff @(posedge clk) begin
		if (state == TX_IDLE && i_enable) begin
			shift_reg <= load_frame;  // capture on acceptance
		end else if (state != TX_IDLE && bit_tick) begin
			shift_reg <= {1'b1, shift_reg[FRAME_BITS-1:1]};  // back-fill with idle level
		end
	end

	// frame sequencing
	always_ff @(posedge clk) begin
		if (reset) begin
			state        <= TX_IDLE;
			bit_cnt      <= '0;
			o_busy       <= 1'b0;
			o_serial_out <= 1'b1;
		end else begin
			case (state)
				TX_IDLE: begin
					if (i_enable) begin
						state  <= TX_WAIT_TICK;
						o_busy <= 1'b1;  // rises on the accepting edge
					end
				end
				TX_WAIT_TICK: begin
					if (bit_tick) begin
						state        <= TX_SEND;
						bit_cnt      <= '0;
						o_serial_out <= shift_reg[0];  // start bit
					end
				end
				TX_SEND: begin
					if (bit_tick) begin
						if (bit_cnt == LAST_BIT) begin
							// stop bit period ends here
							state        <= TX_IDLE;
							o_busy       <= 1'b0;
							o_serial_out <= 1'b1;
						end else begin
							bit_cnt      <= bit_cnt + 1'b1;
							o_serial_out <= shift_reg[0];
						end
					end
				end
				default: begin
					state <= TX_IDLE;
				end
			endcase
		end
	end

	// a request during a frame must not disturb the frame in flight
	a_busy_ignores_enable: assert property (@(posedge clk) disable iff (reset)
		(o_busy && i_enable && !bit_tick) |=> $stable(shift_reg));

	// line idles high between frames
	a_idle_line_high: assert property (@(posedge clk) disable iff (reset)
		(state == TX_IDLE) |-> o_serial_out);

	// busy flag tracks the FSM
	a_busy_matches_state: assert property (@(posedge clk) disable iff (reset)
		o_busy == (state != TX_IDLE));

endmodule

// File: source/uart_rx.sv
`timescale 1ns/10ps

module uart_rx import uart_pkg::*; #(
	parameter int DATA_WIDTH     = DEFAULT_DATA_WIDTH,
	parameter bit PARITY_ENABLED = DEFAULT_PARITY_ENABLED,
	parameter bit PARITY_ODD     = DEFAULT_PARITY_ODD,
	parameter int CLOCKS_PER_BIT = DEFAULT_CLOCKS_PER_BIT
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  i_serial_in,      // asynchronous serial line
	output logic [DATA_WIDTH-1:0] o_received_data,  // held until the next strobe
	output logic                  o_data_valid,     // one cycle per frame
	output logic                  o_rx_error        // parity or framing error
);

	localparam baud_count_t HALF_BIT  = baud_count_t'(CLOCKS_PER_BIT / 2 - 1);
	localparam baud_count_t FULL_BIT  = baud_count_t'(CLOCKS_PER_BIT - 1);
	localparam bit_count_t  LAST_DATA = bit_count_t'(DATA_WIDTH - 1);

	logic [SYNC_STAGES-1:0] sync_q;      // line synchronizer
	logic                   rx_line;     // synchronized line
	rx_state_t              state;
	baud_count_t            baud_cnt;    // clocks since the last sample point
	logic                   sample_now;  // sample point of the current bit
	bit_count_t             bit_idx;     // data bit being received
	logic [DATA_WIDTH-1:0]  shift_reg;   // data assembles here lsb first
	logic                   parity_acc;  // expected parity bit so far
	logic                   parity_err;  // parity mismatch of this frame

	// synchronizer chain feeding rx_line, idle level out of reset
	always_ff @(posedge clk) begin
		if (reset) begin
			sync_q <= '1;
		end else begin
			sync_q <= {sync_q[SYNC_STAGES-2:0], i_serial_in};
		end
	end

	assign rx_line = sync_q[SYNC_STAGES-1];

	// half a period for the start bit, then one full period per bit
	always_comb begin
		if (state == RX_START) begin
			sample_now = (baud_cnt == HALF_BIT);
		end else begin
			sample_now = (baud_cnt == FULL_BIT);
		end
	end

	// FSM and output strobe
	always_ff @(posedge clk) begin
		if (reset) begin
			state           <= RX_IDLE;
			baud_cnt        <= '0;
			bit_idx         <= '0;
			o_data_valid    <= 1'b0;
			o_rx_error      <= 1'b0;
			o_received_data <= '0;
		end else begin
			o_data_valid <= 1'b0;  // strobe lasts a single cycle
			if (state == RX_IDLE || sample_now) begin
				baud_cnt <= '0;  // realign on every sample point
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
			case (state)
				RX_IDLE: begin
					if (!rx_line) begin
						state <= RX_START;  // falling edge
					end
				end
				RX_START: begin
					if (sample_now) begin
						if (rx_line) begin
							state <= RX_IDLE;  // glitch with no frame
						end else begin
							state   <= RX_DATA;
							bit_idx <= '0;
						end
					end
				end
				RX_DATA: begin
					if (sample_now) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == LAST_DATA) begin
							state <= PARITY_ENABLED ? RX_PARITY : RX_STOP;
						end
					end
				end
				RX_PARITY: begin
					if (sample_now) begin
						state <= RX_STOP;
					end
				end
				RX_STOP: begin
					if (sample_now) begin
						state           <= RX_IDLE;
						o_data_valid    <= 1'b1;
						o_received_data <= shift_reg;
						o_rx_error      <= parity_err | ~rx_line;  // low stop bit is a framing error
					end
				end
				default: begin
					state <= RX_IDLE;
				end
			endcase
		end
	end

	// data and parity path
	always_ff @(posedge clk) begin
		if (sample_now) begin
			case (state)
				RX_START: begin
					parity_acc <= PARITY_ODD;  // odd parity starts inverted
					parity_err <= 1'b0;
				end
				RX_DATA: begin
					shift_reg  <= {rx_line, shift_reg[DATA_WIDTH-1:1]};
					parity_acc <= parity_acc ^ rx_line;
				end
				RX_PARITY: begin
					parity_err <= parity_acc ^ rx_line;
				end
				default: begin
					parity_err <= parity_err;
				end
			endcase
		end
	end

	// no back-to-back strobes
	a_valid_single_cycle: assert property (@(posedge clk) disable iff (reset)
		o_data_valid |=> !o_data_valid);

	// a strobe only comes out of the stop bit sample
	a_valid_from_stop: assert property (@(posedge clk) disable iff (reset)
		$rose(o_data_valid) |-> ($past(state) == RX_STOP && state == RX_IDLE));

endmodule

// File: source/uart_top.sv
`timescale 1ns/10ps

module uart_top import uart_pkg::*; #(
	parameter int DATA_WIDTH     = DEFAULT_DATA_WIDTH,
	parameter bit PARITY_ENABLED = DEFAULT_PARITY_ENABLED,
	parameter bit PARITY_ODD     = DEFAULT_PARITY_ODD,
	parameter int CLOCKS_PER_BIT = DEFAULT_CLOCKS_PER_BIT
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  i_enable,         // transmit request
	input  logic [DATA_WIDTH-1:0] i_data,           // word to send
	output logic                  o_busy,           // transmitter busy
	output logic                  o_serial_out,     // transmitter line
	input  logic                  i_loopback,       // 1 feeds the receiver from the transmitter
	input  logic                  i_serial_in,      // external receiver line
	output logic [DATA_WIDTH-1:0] o_received_data,
	output logic                  o_data_valid,
	output logic                  o_rx_error
);

	logic tx_line;  // transmitter output
	logic rx_line;  // receiver input after loopback select

	// mid-bit sampling needs an even divider of at least 4
	if (CLOCKS_PER_BIT < 4 || (CLOCKS_PER_BIT % 2) != 0 || CLOCKS_PER_BIT > 255) begin : g_bad_cpb
		$error("uart_top: CLOCKS_PER_BIT must be even and within 4 to 255");
	end

	// bit_count_t covers up to 16 data bits
	if (DATA_WIDTH < 2 || DATA_WIDTH > 16) begin : g_bad_width
		$error("uart_top: DATA_WIDTH must be within 2 to 16");
	end

	uart_tx #(
		.DATA_WIDTH     (DATA_WIDTH),
		.PARITY_ENABLED (PARITY_ENABLED),
		.PARITY_ODD     (PARITY_ODD),
		.CLOCKS_PER_BIT (CLOCKS_PER_BIT)
	) u_tx (
		.clk          (clk),
		.reset        (reset),
		.i_enable     (i_enable),
		.i_data       (i_data),
		.o_busy       (o_busy),
		.o_serial_out (tx_line)
	);

	assign o_serial_out = tx_line;
	assign rx_line      = i_loopback ? tx_line : i_serial_in;

	uart_rx #(
		.DATA_WIDTH     (DATA_WIDTH),
		.PARITY_ENABLED (PARITY_ENABLED),
		.PARITY_ODD     (PARITY_ODD),
		.CLOCKS_PER_BIT (CLOCKS_PER_BIT)
	) u_rx (
		.clk             (clk),
		.reset           (reset),
		.i_serial_in     (rx_line),
		.o_received_data (o_received_data),
		.o_data_valid    (o_data_valid),
		.o_rx_error      (o_rx_error)
	);

endmodule

// File: bench/tb_uart_tasks.svh
// compare one value and count the outcome
task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
	if (actual !== expected) begin
		fail_count++;
		$display("[FAIL] %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
	end else begin
		pass_count++;
	end
endtask

task automatic report_timeout(input string what);
	fail_count++;
	$display("%s: timed out waiting for %s", test_name, what);
endtask

task automatic begin_test(input string name);
	test_name        = name;
	test_start_fails = fail_count;
endtask

task automatic end_test();
	$display("[done] %s, %0d errors", test_name, fail_count - test_start_fails);
endtask

// returns 1 ns after a rising edge where inputs may change
task automatic idle_cycles(input int n);
	repeat (n) @(posedge clk);
	#1;
endtask

function automatic logic [DATA_WIDTH-1:0] random_word();
	logic [31:0] r;
	r           = $random(seed);
	random_word = r[DATA_WIDTH-1:0];
endfunction

// reference frame with bit 0 first on the line
function automatic logic [FRAME_BITS-1:0] expected_frame(input logic [DATA_WIDTH-1:0] word,
		input logic flip_parity, input logic stop_bit);
	logic [FRAME_BITS-1:0] frame;
	frame               = '0;  // start bit low
	frame[DATA_WIDTH:1] = word;
	if (PARITY_ENABLED) begin
		frame[DATA_WIDTH+1] = (^word) ^ PARITY_ODD ^ flip_parity;  // even parity unless odd selected
	end
	frame[FRAME_BITS-1] = stop_bit;
	return frame;
endfunction

task automatic send_word(input logic [DATA_WIDTH-1:0] word);
	@(posedge clk);
	#1;
	i_enable = 1'b1;
	i_data   = word;
	request_count++;
	@(posedge clk);
	#1;
	i_enable = 1'b0;  // single-cycle request
endtask

task automatic wait_busy_low();
	int waited;
	waited     = 0;
	wait_label = "o_busy to fall";
	while (o_busy !== 1'b0 && waited < WAIT_LIMIT) begin
		@(negedge clk);
		waited++;
	end
	if (o_busy !== 1'b0) begin
		report_timeout("o_busy to fall");
	end
	wait_label = "test sequence";
endtask

// waits until the monitor has seen target strobes in total
task automatic wait_strobes(input int target);
	int waited;
	waited     = 0;
	wait_label = "o_data_valid";
	while (strobe_count < target && waited < WAIT_LIMIT) begin
		@(posedge clk);
		waited++;
	end
	if (strobe_count < target) begin
		report_timeout("o_data_valid");
	end
	wait_label = "test sequence";
endtask

// bit-bangs one frame on the external line
task automatic drive_frame(input logic [DATA_WIDTH-1:0] word, input logic flip_parity,
		input logic stop_bit);
	logic [FRAME_BITS-1:0] frame;
	int i;
	frame = expected_frame(word, flip_parity, stop_bit);
	@(posedge clk);
	#1;
	for (i = 0; i < FRAME_BITS; i++) begin
		i_serial_in = frame[i];
		repeat (CLOCKS_PER_BIT) @(posedge clk);
		#1;
	end
	i_serial_in = 1'b1;  // back to idle
endtask

task automatic check_reset_state();
	begin_test("reset_state");
	repeat (6) begin
		@(negedge clk);
		check_value("o_serial_out", 1, o_serial_out);
		check_value("o_busy", 0, o_busy);
		check_value("o_data_valid", 0, o_data_valid);
		check_value("o_rx_error", 0, o_rx_error);
	end
	check_value("o_received_data", 0, o_received_data);
	idle_cycles(1);
	end_test();
endtask

task automatic check_frame_shape();
	logic [DATA_WIDTH-1:0] word;
	logic [FRAME_BITS-1:0] frame;
	int base;
	int waited;
	int i;
	begin_test("frame_shape");
	i_loopback = 1'b1;
	wait_busy_low();
	word  = random_word();
	frame = expected_frame(word, 1'b0, 1'b1);
	base  = strobe_count;
	send_word(word);
	waited     = 0;
	wait_label = "start bit";
	do begin
		@(negedge clk);
		waited++;
	end while (o_serial_out === 1'b1 && waited < WAIT_LIMIT);
	if (o_serial_out !== 1'b0) begin
		report_timeout("start bit on o_serial_out");
	end else begin
		repeat (CLOCKS_PER_BIT / 2) @(negedge clk);  // middle of the start bit
		for (i = 0; i < FRAME_BITS; i++) begin
			check_value($sformatf("line bit %0d", i), frame[i], o_serial_out);
			if (i < FRAME_BITS - 1) begin
				repeat (CLOCKS_PER_BIT) @(negedge clk);
			end
		end
		check_value("o_busy in stop bit", 1, o_busy);  // falls only at its end
	end
	wait_busy_low();
	check_value("idle line", 1, o_serial_out);
	wait_strobes(base + 1);
	check_value("o_received_data", word, last_data);
	check_value("o_rx_error", 0, last_error);
	end_test();
endtask

task automatic run_loopback_words();
	logic [DATA_WIDTH-1:0] word;
	int base;
	int n;
	begin_test("loopback_data");
	i_loopback = 1'b1;
	for (n = 0; n < 16; n++) begin
		wait_busy_low();
		word = random_word();
		base = strobe_count;
		send_word(word);
		wait_strobes(base + 1);
		check_value($sformatf("word %0d data", n), word, last_data);
		check_value($sformatf("word %0d error", n), 0, last_error);
	end
	end_test();
endtask

task automatic reject_busy_request();
	logic [DATA_WIDTH-1:0] first;
	int base;
	begin_test("ignored_request");
	wait_busy_low();
	first = random_word();
	base  = strobe_count;
	send_word(first);
	idle_cycles(2 * CLOCKS_PER_BIT);  // well inside the frame
	check_value("o_busy at second request", 1, o_busy);
	send_word(~first);  // differs in every bit
	wait_strobes(base + 1);
	check_value("o_received_data", first, last_data);
	check_value("o_rx_error", 0, last_error);
	wait_busy_low();
	idle_cycles(2 * FRAME_CYCLES);
	check_value("strobes for two requests", 1, strobe_count - base);
	end_test();
endtask

task automatic detect_parity_error();
	logic [DATA_WIDTH-1:0] word;
	int base;
	begin_test("parity_error");
	wait_busy_low();
	i_loopback = 1'b0;  // receiver listens to the external pin
	word = random_word();
	base = strobe_count;
	drive_frame(word, 1'b1, 1'b1);
	wait_strobes(base + 1);
	check_value("o_rx_error", 1, last_error);
	check_value("o_received_data", word, last_data);
	idle_cycles(CLOCKS_PER_BIT);
	end_test();
endtask

task automatic detect_framing_and_glitch();
	logic [DATA_WIDTH-1:0] word;
	int base;
	begin_test("framing_and_glitch");
	i_loopback = 1'b0;
	word = random_word();
	base = strobe_count;
	drive_frame(word, 1'b0, 1'b0);  // stop bit low
	wait_strobes(base + 1);
	check_value("o_rx_error", 1, last_error);
	check_value("o_received_data", word, last_data);
	idle_cycles(FRAME_CYCLES);
	check_value("strobes after bad stop", 1, strobe_count - base);
	base        = strobe_count;
	i_serial_in = 1'b0;
	idle_cycles(CLOCKS_PER_BIT / 2 - 1);  // shorter than half a bit
	i_serial_in = 1'b1;
	idle_cycles(2 * FRAME_CYCLES);
	check_value("strobes after glitch", 0, strobe_count - base);
	end_test();
endtask

// File: bench/tb_uart.sv
`timescale 1ns/10ps

module tb_uart import uart_pkg::*; ();

	localparam int DATA_WIDTH      = DEFAULT_DATA_WIDTH;
	localparam bit PARITY_ENABLED  = DEFAULT_PARITY_ENABLED;
	localparam bit PARITY_ODD      = DEFAULT_PARITY_ODD;
	localparam int CLOCKS_PER_BIT  = DEFAULT_CLOCKS_PER_BIT;
	localparam int FRAME_BITS      = DATA_WIDTH + int'(PARITY_ENABLED) + 2;  // start, data, parity, stop
	localparam int CLK_PERIOD      = 4;                                      // ns
	localparam int FRAME_CYCLES    = (FRAME_BITS + 2) * CLOCKS_PER_BIT;      // one frame plus slack
	localparam int WAIT_LIMIT      = 2 * FRAME_CYCLES;                       // per-wait timeout
	localparam int WATCHDOG_FRAMES = 30;  // frames sent plus idle windows rounded up
	localparam int WATCHDOG_NS     = WATCHDOG_FRAMES * FRAME_CYCLES * CLK_PERIOD + 400;

	logic                  clk;
	logic                  reset;
	logic                  i_enable;
	logic [DATA_WIDTH-1:0] i_data;
	logic                  o_busy;
	logic                  o_serial_out;
	logic                  i_loopback;
	logic                  i_serial_in;
	logic [DATA_WIDTH-1:0] o_received_data;
	logic                  o_data_valid;
	logic                  o_rx_error;

	integer                seed = 32'h0843eb96;  // fixed seed for $random
	int                    pass_count = 0;
	int                    fail_count = 0;
	int                    test_start_fails = 0;
	int                    request_count = 0;    // words offered to the transmitter
	int                    strobe_count = 0;     // o_data_valid pulses seen
	logic [DATA_WIDTH-1:0] last_data = '0;       // word captured with the last strobe
	logic                  last_error = 1'b0;    // error flag captured with the last strobe
	string                 test_name = "none";
	string                 wait_label = "reset";  // what the sequence is blocked on

	`include "tb_uart_tasks.svh"

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;  // 4 ns period

	uart_top u_uart_top (
		.clk             (clk),
		.reset           (reset),
		.i_enable        (i_enable),
		.i_data          (i_data),
		.o_busy          (o_busy),
		.o_serial_out    (o_serial_out),
		.i_loopback      (i_loopback),
		.i_serial_in     (i_serial_in),
		.o_received_data (o_received_data),
		.o_data_valid    (o_data_valid),
		.o_rx_error      (o_rx_error)
	);

	// strobe monitor sampling mid-cycle where outputs are settled
	always @(negedge clk) begin
		if (!reset && o_data_valid) begin
			strobe_count <= strobe_count + 1;
			last_data    <= o_received_data;
			last_error   <= o_rx_error;
		end
	end

	// watchdog sized from the total frame traffic
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired in %s while waiting for %s", test_name, wait_label);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		reset       = 1'b1;
		i_enable    = 1'b0;
		i_data      = '0;
		i_loopback  = 1'b1;
		i_serial_in = 1'b1;  // external line idles high
		repeat (4) @(posedge clk);
		#1;
		reset      = 1'b0;
		wait_label = "test sequence";

		check_reset_state();
		check_frame_shape();
		run_loopback_words();
		reject_busy_request();
		detect_parity_error();
		detect_framing_and_glitch();

		$display("checks: %0d passed, %0d failed (%0d requests, %0d strobes)",
			pass_count, fail_count, request_count, strobe_count);
		if (fail_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: flist.f
+incdir+bench
source/uart_pkg.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_top.sv
bench/tb_uart.sv
